// File: flist.f
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/ifu.sv
rtl/idu.sv
rtl/witf.sv
rtl/exu.sv
rtl/wbu.sv
rtl/top.sv
dv/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_top
RTL_TOP   := top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import cpu_pkg::*;
();

  localparam logic [XLEN-1:0] RESET_PC       = 64'h8000_0000;
  localparam int              WITF_DEPTH     = 4;
  localparam int              N_RAND         = 300;
  localparam int              PROG_LEN       = N_RAND + 1;
  localparam int              RETIRE_TIMEOUT = 2000;
  localparam int              FETCH_TIMEOUT  = 20;
  localparam int              HALT_WATCH     = 50;
  // addi x0, x0, 0 past the end of the program
  localparam logic [ILEN-1:0] NOP_INST       = 32'h0000_0013;

  logic              clk;
  logic              i_rst;
  logic              o_fetch_req;
  logic [XLEN-1:0]   o_fetch_addr;
  logic              i_fetch_valid;
  logic [ILEN-1:0]   i_fetch_inst;
  logic              o_retire_valid;
  logic [XLEN-1:0]   o_retire_pc;
  logic [ILEN-1:0]   o_retire_inst;
  logic              o_retire_wen;
  logic [REG_AW-1:0] o_retire_rd;
  logic [XLEN-1:0]   o_retire_wdata;
  logic              o_halted;

  logic [31:0]       lfsr_state;
  logic [ILEN-1:0]   prog [PROG_LEN];
  logic [XLEN-1:0]   model_regs [32];
  logic              ebreak_fetched;

  top #(
    .RESET_PC(RESET_PC),
    .WITF_DEPTH(WITF_DEPTH)
  ) DUT (
    .clk(clk), .i_rst(i_rst),
    .o_fetch_req(o_fetch_req), .o_fetch_addr(o_fetch_addr),
    .i_fetch_valid(i_fetch_valid), .i_fetch_inst(i_fetch_inst),
    .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
    .o_retire_inst(o_retire_inst), .o_retire_wen(o_retire_wen),
    .o_retire_rd(o_retire_rd), .o_retire_wdata(o_retire_wdata),
    .o_halted(o_halted)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // mostly x0..x7 so dependency chains stay dense
  function automatic logic [4:0] rand_reg();
    logic [4:0] r;
    if (rand_bits(3) == 0) begin
      r = 5'(rand_bits(5));
    end else begin
      r = 5'(rand_bits(3));
    end
    return r;
  endfunction

  function automatic logic [ILEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [ILEN-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [ILEN-1:0] gen_inst();
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [11:0]     imm;
    logic [5:0]      shamt;
    logic [19:0]     imm_u;
    logic [24:0]     junk;
    logic [6:0]      opc;
    int              kind;
    logic [ILEN-1:0] inst;
    rd    = rand_reg();
    rs1   = rand_reg();
    rs2   = rand_reg();
    imm   = 12'(rand_bits(12));
    shamt = 6'(rand_bits(6));
    imm_u = 20'(rand_bits(20));
    // about 5 percent unsupported
    if (rand_bits(6) < 3) begin
      // load, store, op-imm-32, op-32
      case (rand_bits(2))
        0:       opc = 7'b0000011;
        1:       opc = 7'b0100011;
        2:       opc = 7'b0011011;
        default: opc = 7'b0111011;
      endcase
      junk = 25'(rand_bits(25));
      return {junk, opc};
    end
    kind = int'(rand_bits(5) % 20);
    case (kind)
      0:       inst = enc_i(imm, rs1, 3'b000, rd);
      1:       inst = enc_i(imm, rs1, 3'b010, rd);
      2:       inst = enc_i(imm, rs1, 3'b011, rd);
      3:       inst = enc_i(imm, rs1, 3'b100, rd);
      4:       inst = enc_i(imm, rs1, 3'b110, rd);
      5:       inst = enc_i(imm, rs1, 3'b111, rd);
      6:       inst = enc_i({6'b000000, shamt}, rs1, 3'b001, rd);
      7:       inst = enc_i({6'b000000, shamt}, rs1, 3'b101, rd);
      8:       inst = enc_i({6'b010000, shamt}, rs1, 3'b101, rd);
      9:       inst = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
      10:      inst = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
      11:      inst = enc_r(7'b0000000, rs2, rs1, 3'b001, rd);
      12:      inst = enc_r(7'b0000000, rs2, rs1, 3'b010, rd);
      13:      inst = enc_r(7'b0000000, rs2, rs1, 3'b011, rd);
      14:      inst = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
      15:      inst = enc_r(7'b0000000, rs2, rs1, 3'b101, rd);
      16:      inst = enc_r(7'b0100000, rs2, rs1, 3'b101, rd);
      17:      inst = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
      18:      inst = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
      default: inst = {imm_u, rd, OPC_LUI};
    endcase
    return inst;
  endfunction

  // rv64i alu semantics, alt picks sub / sra
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic signed [XLEN-1:0] sr;
    sa = a;
    sb = b;
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[5:0];
      3'b010: return (sa < sb) ? 64'd1 : 64'd0;
      3'b011: return (a < b) ? 64'd1 : 64'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          sr = sa >>> b[5:0];
          return sr;
        end
        return a >> b[5:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // in-order reference step, x0 never written
  task automatic model_step(input logic [ILEN-1:0] inst, output logic wen,
                            output logic [4:0] rd, output logic [XLEN-1:0] val);
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    f3  = inst[14:12];
    rd  = inst[11:7];
    a   = model_regs[inst[19:15]];
    wen = 1'b0;
    val = '0;
    case (inst[6:0])
      OPC_OP_IMM: begin
        b   = {{(XLEN-12){inst[31]}}, inst[31:20]};
        val = alu_ref(f3, (f3 == 3'b101) && inst[30], a, b);
        wen = 1'b1;
      end
      OPC_OP: begin
        b   = model_regs[inst[24:20]];
        val = alu_ref(f3, inst[30], a, b);
        wen = 1'b1;
      end
      OPC_LUI: begin
        val = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
        wen = 1'b1;
      end
      default: wen = 1'b0;
    endcase
    if (rd == '0) begin
      wen = 1'b0;
    end
    if (wen) begin
      model_regs[rd] = val;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] exp_v,
                             input logic [XLEN-1:0] act_v);
    assert (act_v === exp_v) else begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [ILEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = (addr - RESET_PC) >> 2;
    if (idx < PROG_LEN) begin
      return prog[int'(idx)];
    end
    return NOP_INST;
  endfunction

  // memory model, one request at a time, 1 to 4 cycles late
  task automatic serve_fetches();
    logic [XLEN-1:0] expect_addr;
    logic [XLEN-1:0] addr;
    int              delay;
    int              idle;
    int              count;
    bit              serving;
    expect_addr = RESET_PC;
    count       = 0;
    serving     = 1'b1;
    while (serving) begin
      idle = 0;
      do begin
        @(negedge clk);
        idle++;
      end while (!o_fetch_req && idle < FETCH_TIMEOUT);
      if (!o_fetch_req) begin
        // only a halted core may stop asking
        assert (ebreak_fetched) else report_failure("fetched item never consumed");
        serving = 1'b0;
      end else begin
        // sequential pc, first one at reset pc
        addr = o_fetch_addr;
        check_value($sformatf("fetch_addr[%0d]", count), expect_addr, addr);
        expect_addr = expect_addr + 64'd4;
        count++;
        if (addr == RESET_PC + XLEN'(4 * N_RAND)) begin
          ebreak_fetched = 1'b1;
        end
        delay = 1 + int'(rand_bits(2));
        repeat (delay) @(posedge clk);
        #1;
        i_fetch_valid = 1'b1;
        i_fetch_inst  = fetch_word(addr);
        @(posedge clk);
        #1;
        i_fetch_valid = 1'b0;
        i_fetch_inst  = '0;
      end
    end
  endtask

  // no halt may show before ebreak retires
  task automatic wait_retire(input int idx);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      check_value($sformatf("halted_early[%0d]", idx), 64'd0, o_halted);
      assert (n <= RETIRE_TIMEOUT) else report_failure("no retirement within timeout");
    end while (!o_retire_valid);
  endtask

  task automatic check_quiet(input string phase);
    check_value({phase, "_retire_valid"}, 64'd0, o_retire_valid);
    check_value({phase, "_halted"}, 64'd0, o_halted);
    check_value({phase, "_fetch_req"}, 64'd0, o_fetch_req);
  endtask

  initial begin
    logic            exp_wen;
    logic [4:0]      exp_rd;
    logic [XLEN-1:0] exp_val;
    logic [XLEN-1:0] exp_pc;
    clk            = 1'b0;
    i_rst          = 1'b1;
    i_fetch_valid  = 1'b0;
    i_fetch_inst   = '0;
    lfsr_state     = 32'h745d38b3;
    ebreak_fetched = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < N_RAND; i++) begin
      prog[i] = gen_inst();
    end
    prog[N_RAND] = INST_EBREAK;

    // reset for 5 cycles
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
      check_quiet("reset");
    end
    i_rst = 1'b0;
    fork
      serve_fetches();
    join_none
    @(negedge clk);
    check_quiet("post_reset");

    for (int k = 0; k < PROG_LEN; k++) begin
      wait_retire(k);
      exp_pc = RESET_PC + XLEN'(4 * k);
      check_value($sformatf("retire_pc[%0d]", k), exp_pc, o_retire_pc);
      check_value($sformatf("retire_inst[%0d]", k), prog[k], o_retire_inst);
      model_step(prog[k], exp_wen, exp_rd, exp_val);
      check_value($sformatf("retire_wen[%0d]", k), exp_wen, o_retire_wen);
      if (exp_wen) begin
        check_value($sformatf("retire_rd[%0d]", k), exp_rd, o_retire_rd);
        check_value($sformatf("retire_wdata[%0d]", k), exp_val, o_retire_wdata);
      end
    end

    // ebreak just retired
    @(negedge clk);
    check_value("halted", 64'd1, o_halted);
    repeat (HALT_WATCH) begin
      @(negedge clk);
      assert (!o_fetch_req) else report_failure("fetch request after halt");
      assert (!o_retire_valid) else report_failure("retirement after halt");
      check_value("halted_hold", 64'd1, o_halted);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// File: rtl/top.sv
`timescale 1ns/1ps

module top
  import cpu_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC   = 64'h8000_0000,
  parameter int              WITF_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  // instruction memory
  output logic              o_fetch_req,
  output logic [XLEN-1:0]   o_fetch_addr,
  input  logic              i_fetch_valid,
  input  logic [ILEN-1:0]   i_fetch_inst,
  // retire trace
  output logic              o_retire_valid,
  output logic [XLEN-1:0]   o_retire_pc,
  output logic [ILEN-1:0]   o_retire_inst,
  output logic              o_retire_wen,
  output logic [REG_AW-1:0] o_retire_rd,
  output logic [XLEN-1:0]   o_retire_wdata,
  output logic              o_halted
);

  // if stage
  logic   if_valid;
  logic   if_ready_go;
  if_id_t if_out;
  // id stage
  logic   id_allow_in;
  logic   id_valid;
  logic   id_ready_go;
  if_id_t id_in;
  id_ex_t id_out;
  // ex stage
  logic   ex_allow_in;
  logic   ex_valid;
  logic   ex_ready_go;
  id_ex_t ex_in;
  ex_wb_t ex_out;
  // wb stage
  logic   wb_allow_in;
  logic   wb_valid;
  logic   wb_ready_go;
  ex_wb_t wb_in;
  // register read, witf, halt
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              witf_push;
  logic [REG_AW-1:0] witf_rd;
  logic              witf_pop;
  logic              witf_full;
  logic              raw_hit;
  logic              ebreak_seen;

  ifu #(.RESET_PC(RESET_PC)) u_ifu (
    .clk(clk), .i_rst(i_rst),
    .o_fetch_req(o_fetch_req), .o_fetch_addr(o_fetch_addr),
    .i_fetch_valid(i_fetch_valid), .i_fetch_inst(i_fetch_inst),
    .i_ebreak_seen(ebreak_seen),
    .i_allow_in(id_allow_in), .o_valid(if_valid), .o_ready_go(if_ready_go),
    .o_payload(if_out)
  );

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .i_rst(i_rst),
    .i_valid(if_valid), .i_ready_go(if_ready_go), .i_payload(if_out),
    .o_allow_in(id_allow_in), .o_valid(id_valid), .o_payload(id_in),
    .i_next_ready_go(id_ready_go), .i_next_allow_in(ex_allow_in)
  );

  idu u_idu (
    .clk(clk), .i_rst(i_rst),
    .i_valid(id_valid), .i_payload(id_in), .o_ready_go(id_ready_go),
    .i_allow_in(ex_allow_in), .o_payload(id_out),
    .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_witf_push(witf_push), .o_witf_rd(witf_rd),
    .i_raw_hit(raw_hit), .i_witf_full(witf_full),
    .o_ebreak_seen(ebreak_seen)
  );

  // lookup qualified by a live decode item
  witf #(.WITF_DEPTH(WITF_DEPTH)) u_witf (
    .clk(clk), .i_rst(i_rst),
    .i_rs1(rs1), .i_rs2(rs2), .i_check(id_valid), .o_raw_hit(raw_hit),
    .i_push(witf_push), .i_rd(witf_rd), .i_pop(witf_pop), .o_full(witf_full)
  );

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .i_rst(i_rst),
    .i_valid(id_valid), .i_ready_go(id_ready_go), .i_payload(id_out),
    .o_allow_in(ex_allow_in), .o_valid(ex_valid), .o_payload(ex_in),
    .i_next_ready_go(ex_ready_go), .i_next_allow_in(wb_allow_in)
  );

  exu u_exu (
    .clk(clk), .i_rst(i_rst),
    .i_valid(ex_valid), .i_payload(ex_in), .o_ready_go(ex_ready_go),
    .i_allow_in(wb_allow_in), .o_payload(ex_out)
  );

  // nothing after wb, so it always drains
  pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
    .clk(clk), .i_rst(i_rst),
    .i_valid(ex_valid), .i_ready_go(ex_ready_go), .i_payload(ex_out),
    .o_allow_in(wb_allow_in), .o_valid(wb_valid), .o_payload(wb_in),
    .i_next_ready_go(wb_ready_go), .i_next_allow_in(1'b1)
  );

  wbu u_wbu (
    .clk(clk), .i_rst(i_rst),
    .i_valid(wb_valid), .i_payload(wb_in), .o_ready_go(wb_ready_go),
    .i_rs1(rs1), .i_rs2(rs2), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .o_witf_pop(witf_pop),
    .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
    .o_retire_inst(o_retire_inst), .o_retire_wen(o_retire_wen),
    .o_retire_rd(o_retire_rd), .o_retire_wdata(o_retire_wdata),
    .o_halted(o_halted)
  );

endmodule

// File: rtl/wbu.sv
`timescale 1ns/1ps

module wbu
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  // from ex/wb
  input  logic              i_valid,
  input  ex_wb_t            i_payload,
  output logic              o_ready_go,
  // read ports for decode
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data,
  // witf release
  output logic              o_witf_pop,
  // retire trace
  output logic              o_retire_valid,
  output logic [XLEN-1:0]   o_retire_pc,
  output logic [ILEN-1:0]   o_retire_inst,
  output logic              o_retire_wen,
  output logic [REG_AW-1:0] o_retire_rd,
  output logic [XLEN-1:0]   o_retire_wdata,
  output logic              o_halted
);

  logic [XLEN-1:0] regs [1:31];
  logic            we;
  logic            halted_q;

  assign we = i_valid && i_payload.wen;

  // x1..x31, all zero out of reset
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[i_payload.rd] <= i_payload.result;
    end
  end

  // x0 hardwired, no write bypass
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      halted_q <= 1'b0;
    end else if (i_valid && (i_payload.inst == INST_EBREAK)) begin
      halted_q <= 1'b1;
    end
  end

  // last stage, always drains
  assign o_ready_go = 1'b1;
  assign o_witf_pop = we;

  assign o_retire_valid = i_valid;
  assign o_retire_pc    = i_payload.pc;
  assign o_retire_inst  = i_payload.inst;
  assign o_retire_wen   = we;
  assign o_retire_rd    = i_payload.rd;
  assign o_retire_wdata = i_payload.result;
  assign o_halted       = halted_q;

endmodule

// File: rtl/exu.sv
`timescale 1ns/1ps

module exu
  import cpu_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst,
  // from id/ex
  input  logic   i_valid,
  input  id_ex_t i_payload,
  output logic   o_ready_go,
  // to ex/wb
  input  logic   i_allow_in,
  output ex_wb_t o_payload
);

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [5:0]      shamt;
  logic [XLEN-1:0] res;

  assign a     = i_payload.opa;
  assign b     = i_payload.opb;
  // rv64 shifts take six bits
  assign shamt = b[5:0];

  always_comb begin
    case (i_payload.alu_op)
      ALU_ADD:   res = a + b;
      ALU_SUB:   res = a - b;
      ALU_SLL:   res = a << shamt;
      ALU_SLT:   res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:  res = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:   res = a ^ b;
      ALU_SRL:   res = a >> shamt;
      ALU_SRA:   res = $unsigned($signed(a) >>> shamt);
      ALU_OR:    res = a | b;
      ALU_AND:   res = a & b;
      ALU_PASSB: res = b;
      default:   res = '0;
    endcase
  end

  // single cycle alu never holds its item
  assign o_ready_go = 1'b1;

  assign o_payload.pc     = i_payload.pc;
  assign o_payload.inst   = i_payload.inst;
  assign o_payload.rd     = i_payload.rd;
  assign o_payload.wen    = i_payload.wen;
  assign o_payload.result = res;

endmodule

// File: rtl/witf.sv
`timescale 1ns/1ps

module witf
  import cpu_pkg::*;
#(
  parameter int WITF_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  // lookup from decode
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  input  logic              i_check,
  output logic              o_raw_hit,
  // dispatch
  input  logic              i_push,
  input  logic [REG_AW-1:0] i_rd,
  // writeback
  input  logic              i_pop,
  output logic              o_full
);

  localparam int AW = $clog2(WITF_DEPTH);

  logic [REG_AW-1:0] rd_mem [WITF_DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;
  logic [AW-1:0]     offs;
  logic              hit;

  // scan every slot, live ones sit within count of rd_ptr
  always_comb begin
    hit  = 1'b0;
    offs = '0;
    for (int i = 0; i < WITF_DEPTH; i++) begin
      offs = AW'(i) - rd_ptr;
      if (({1'b0, offs} < count) && ((rd_mem[i] == i_rs1) || (rd_mem[i] == i_rs2))) begin
        hit = 1'b1;
      end
    end
  end

  assign o_raw_hit = i_check && hit;
  assign o_full    = count == (AW+1)'(WITF_DEPTH);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // writebacks retire in dispatch order
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      rd_mem[wr_ptr] <= i_rd;
    end
  end

endmodule

// File: rtl/idu.sv
`timescale 1ns/1ps

module idu
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  // from if/id
  input  logic              i_valid,
  input  if_id_t            i_payload,
  output logic              o_ready_go,
  // to id/ex
  input  logic              i_allow_in,
  output id_ex_t            o_payload,
  // register file read
  output logic [REG_AW-1:0] o_rs1,
  output logic [REG_AW-1:0] o_rs2,
  input  logic [XLEN-1:0]   i_rs1_data,
  input  logic [XLEN-1:0]   i_rs2_data,
  // witf
  output logic              o_witf_push,
  output logic [REG_AW-1:0] o_witf_rd,
  input  logic              i_raw_hit,
  input  logic              i_witf_full,
  // to fetch
  output logic              o_ebreak_seen
);

  logic [ILEN-1:0]   inst;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rd;
  logic              is_op_imm;
  logic              is_op;
  logic              is_lui;
  logic              is_ebreak;
  logic              supported;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  logic              wen;
  logic              fire;
  logic              stopped_q;

  assign inst   = i_payload.inst;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign is_op_imm = opcode == OPC_OP_IMM;
  assign is_op     = opcode == OPC_OP;
  assign is_lui    = opcode == OPC_LUI;
  assign is_ebreak = (opcode == OPC_SYSTEM) && (inst == INST_EBREAK);

  always_comb begin
    alu_op    = ALU_ADD;
    supported = 1'b0;
    if (is_lui) begin
      alu_op    = ALU_PASSB;
      supported = 1'b1;
    end else if (is_op || is_op_imm) begin
      supported = 1'b1;
      case (funct3)
        3'b000: begin
          // addi never subtracts, imm bit 10 is data
          if (is_op && funct7[5]) begin
            alu_op = ALU_SUB;
          end else begin
            alu_op = ALU_ADD;
          end
        end
        3'b001: alu_op = ALU_SLL;
        3'b010: alu_op = ALU_SLT;
        3'b011: alu_op = ALU_SLTU;
        3'b100: alu_op = ALU_XOR;
        3'b101: begin
          if (funct7[5]) begin
            alu_op = ALU_SRA;
          end else begin
            alu_op = ALU_SRL;
          end
        end
        3'b110: alu_op = ALU_OR;
        default: alu_op = ALU_AND;
      endcase
      // reject unused funct7 / funct6 patterns
      if (is_op) begin
        if (funct7 == 7'b0100000) begin
          supported = (funct3 == 3'b000) || (funct3 == 3'b101);
        end else begin
          supported = funct7 == 7'b0;
        end
      end else if (funct3 == 3'b001) begin
        supported = inst[31:26] == 6'b0;
      end else if (funct3 == 3'b101) begin
        supported = (inst[31:26] == 6'b0) || (inst[31:26] == 6'b010000);
      end
    end
  end

  // immediates, both sign extended
  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};

  // unused source fields read as x0 so they never raise a raw hit
  assign o_rs1 = (is_op || is_op_imm) ? inst[19:15] : '0;
  assign o_rs2 = is_op ? inst[24:20] : '0;

  // x0 and unknown opcodes write nothing
  assign wen = supported && (rd != '0);

  // stall on hazard, on a full table, or after ebreak
  assign o_ready_go = !stopped_q && !i_raw_hit && !(wen && i_witf_full);
  assign fire       = i_valid && o_ready_go && i_allow_in;

  assign o_witf_push   = fire && wen;
  assign o_witf_rd     = rd;
  assign o_ebreak_seen = fire && is_ebreak;

  // nothing behind ebreak is dispatched
  always_ff @(posedge clk) begin
    if (i_rst) begin
      stopped_q <= 1'b0;
    end else if (o_ebreak_seen) begin
      stopped_q <= 1'b1;
    end
  end

  assign o_payload.pc     = i_payload.pc;
  assign o_payload.inst   = inst;
  assign o_payload.alu_op = alu_op;
  // lui adds nothing to its immediate
  assign o_payload.opa    = is_lui ? '0 : i_rs1_data;
  assign o_payload.opb    = is_op ? i_rs2_data : (is_lui ? imm_u : imm_i);
  assign o_payload.rd     = rd;
  assign o_payload.wen    = wen;

endmodule

// File: rtl/ifu.sv
`timescale 1ns/1ps

module ifu
  import cpu_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000
) (
  input  logic            clk,
  input  logic            i_rst,
  // instruction memory
  output logic            o_fetch_req,
  output logic [XLEN-1:0] o_fetch_addr,
  input  logic            i_fetch_valid,
  input  logic [ILEN-1:0] i_fetch_inst,
  // from decode
  input  logic            i_ebreak_seen,
  // handshake with if/id
  input  logic            i_allow_in,
  output logic            o_valid,
  output logic            o_ready_go,
  output if_id_t          o_payload
);

  logic [XLEN-1:0] pc_q;
  logic            req_q;
  logic            wait_q;
  logic            hold_q;
  logic [ILEN-1:0] inst_q;
  logic            halt_q;
  logic            take;
  logic            issue;

  // answer passes straight on when if/id has room
  // otherwise parked in inst_q
  assign o_valid        = hold_q || (wait_q && i_fetch_valid);
  assign o_ready_go     = 1'b1;
  assign o_payload.pc   = pc_q;
  assign o_payload.inst = hold_q ? inst_q : i_fetch_inst;

  assign take = o_valid && i_allow_in;

  // idle, or the current item is leaving
  // stop for good once ebreak has gone to ex
  assign issue = !halt_q && !i_ebreak_seen && ((!wait_q && !hold_q) || take);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pc_q   <= RESET_PC;
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      hold_q <= 1'b0;
      halt_q <= 1'b0;
    end else begin
      // single cycle request pulse
      req_q <= issue;
      if (i_ebreak_seen) begin
        halt_q <= 1'b1;
      end
      // one outstanding request at a time
      if (issue) begin
        wait_q <= 1'b1;
      end else if (wait_q && i_fetch_valid) begin
        wait_q <= 1'b0;
      end
      if (take) begin
        pc_q   <= pc_q + XLEN'(4);
        hold_q <= 1'b0;
      end else if (wait_q && i_fetch_valid) begin
        hold_q <= 1'b1;
      end
    end
  end

  // parked instruction
  always_ff @(posedge clk) begin
    if (wait_q && i_fetch_valid && !i_allow_in) begin
      inst_q <= i_fetch_inst;
    end
  end

  // address is the already advanced pc
  assign o_fetch_req  = req_q;
  assign o_fetch_addr = pc_q;

endmodule

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     i_rst,
  // upstream side
  input  logic     i_valid,
  input  logic     i_ready_go,
  input  payload_t i_payload,
  output logic     o_allow_in,
  // downstream side
  output logic     o_valid,
  output payload_t o_payload,
  input  logic     i_next_ready_go,
  input  logic     i_next_allow_in
);

  logic     valid_q;
  payload_t payload_q;

  // empty, or current item leaves this cycle
  assign o_allow_in = !valid_q || (i_next_ready_go && i_next_allow_in);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_allow_in) begin
      // refill or drain
      valid_q <= i_valid && i_ready_go;
    end
  end

  // load only on a real transfer
  always_ff @(posedge clk) begin
    if (o_allow_in && i_valid && i_ready_go) begin
      payload_q <= i_payload;
    end
  end

  assign o_valid   = valid_q;
  assign o_payload = payload_q;

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

  // machine widths
  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int REG_AW = 5;

  // major opcodes handled by the core
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // full ebreak word, funct12 = 1 under system
  localparam logic [ILEN-1:0] INST_EBREAK = 32'h0010_0073;

  // alu operations
  // passb forwards operand b untouched, used by lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } alu_op_e;

  // if -> id
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] inst;
  } if_id_t;

  // id -> ex, operands already resolved
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [ILEN-1:0]   inst;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   opa;
    logic [XLEN-1:0]   opb;
    logic [REG_AW-1:0] rd;
    logic              wen;
  } id_ex_t;

  // ex -> wb
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [ILEN-1:0]   inst;
    logic [REG_AW-1:0] rd;
    logic              wen;
    logic [XLEN-1:0]   result;
  } ex_wb_t;

endpackage
